/* source/periph_pkg.sv */
// shared widths, address map and bus and register encodings for the peripheral subsystem
package periph_pkg;

	// data path
	localparam int word_data_w = 32;	// bus data word
	localparam int addr_w = 8;	// master address width

	// address map
	localparam int slave_sel_w = 2;	// region field in top address bits
	localparam int reg_addr_w = 2;	// register index in low address bits

	localparam logic [slave_sel_w-1:0] timer_region = 2'd0;	// interval timer
	localparam logic [slave_sel_w-1:0] gpio_region = 2'd1;	// i/o port
	// regions 2 and 3 left unmapped, answered by the decoder

	// bus opcode
	typedef enum logic {
		bus_write = 1'b0,	// rw low
		bus_read = 1'b1	// rw high
	} bus_rw_e;

	// timer run mode, ctrl bit 1
	typedef enum logic {
		timer_one_shot = 1'b0,	// stop after first expiry
		timer_periodic = 1'b1	// reload and keep counting
	} timer_mode_e;

	// timer register indices
	typedef enum logic [reg_addr_w-1:0] {
		timer_ctrl = 2'd0,	// mode and start
		timer_intr = 2'd1,	// sticky irq
		timer_expr = 2'd2,	// expiry compare value
		timer_counter = 2'd3	// running count
	} timer_reg_e;

	// gpio register indices, index 3 reads zero
	typedef enum logic [reg_addr_w-1:0] {
		gpio_out_data = 2'd0,	// output latch
		gpio_dir = 2'd1,	// 1 = drive pin
		gpio_in_data = 2'd2	// synchronised pins, read only
	} gpio_reg_e;

	// bit positions inside timer registers
	localparam int timer_start_loc = 0;	// ctrl
	localparam int timer_mode_loc = 1;	// ctrl
	localparam int timer_irq_loc = 0;	// intr

	// pin count of the i/o port
	localparam int gpio_w = 8;

endpackage

/* source/periph_bus_if.sv */
`timescale 1ns/10ps
// one slave's strobe bus between the decoder and a peripheral
interface periph_bus_if;
	import periph_pkg::*;

	logic cs_n;	// chip select, low active
	logic as_n;	// address strobe, low active
	bus_rw_e rw;	// read or write
	logic [reg_addr_w-1:0] addr;	// register index only
	logic [word_data_w-1:0] wr_data;	// write data
	logic [word_data_w-1:0] rd_data;	// zero when idle
	logic rdy_n;	// high when idle

	// decoder side
	modport master (
		output cs_n, as_n, rw, addr, wr_data,
		input rd_data, rdy_n
	);

	// peripheral side
	modport slave (
		input cs_n, as_n, rw, addr, wr_data,
		output rd_data, rdy_n
	);

endinterface

/* source/bus_decoder.sv */
`timescale 1ns/10ps
// steers master strobes to the addressed slave and answers unmapped regions itself
module bus_decoder (
	input logic clk,
	input logic reset,
	input logic cs_n,
	input logic as_n,
	input periph_pkg::bus_rw_e rw,
	input logic [periph_pkg::addr_w-1:0] addr,
	input logic [periph_pkg::word_data_w-1:0] wr_data,
	output logic [periph_pkg::word_data_w-1:0] rd_data,
	output logic rdy_n,
	periph_bus_if.master timer_bus,
	periph_bus_if.master gpio_bus
);
	import periph_pkg::*;

	logic [slave_sel_w-1:0] slave_sel;	// region field
	logic timer_hit;
	logic gpio_hit;
	logic unmapped_acc;	// strobed access to region 2 or 3
	logic unmap_rdy_n;	// registered answer for unmapped

	assign slave_sel = addr[addr_w-1 -: slave_sel_w];	// top bits pick the region
	assign timer_hit = (slave_sel == timer_region);
	assign gpio_hit = (slave_sel == gpio_region);
	assign unmapped_acc = !cs_n && !as_n && !timer_hit && !gpio_hit;

	// timer strobes, select gated per region
	assign timer_bus.cs_n = cs_n | !timer_hit;
	assign timer_bus.as_n = as_n;
	assign timer_bus.rw = rw;
	assign timer_bus.addr = addr[reg_addr_w-1:0];	// register index only
	assign timer_bus.wr_data = wr_data;

	// gpio strobes
	assign gpio_bus.cs_n = cs_n | !gpio_hit;
	assign gpio_bus.as_n = as_n;
	assign gpio_bus.rw = rw;
	assign gpio_bus.addr = addr[reg_addr_w-1:0];
	assign gpio_bus.wr_data = wr_data;

	// unmapped answer, one cycle late like a real slave
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			unmap_rdy_n <= 1'b1;	// idle
		end
		else
		begin
			unmap_rdy_n <= !unmapped_acc;
		end
	end

	// idle slaves give zero and high, so or and and merge cleanly
	assign rd_data = timer_bus.rd_data | gpio_bus.rd_data;	// unmapped adds nothing
	assign rdy_n = timer_bus.rdy_n & gpio_bus.rdy_n & unmap_rdy_n;

endmodule

/* source/timer.sv */
`timescale 1ns/10ps
// interval timer with expiry compare, one-shot or periodic run and a sticky interrupt
module timer (
	input logic clk,
	input logic reset,
	periph_bus_if.slave bus,
	output logic irq	// level, held until cleared through intr
);
	import periph_pkg::*;

	timer_mode_e mode;	// ctrl bit 1
	logic start;	// ctrl bit 0, counting enabled
	logic [word_data_w-1:0] expr_val;	// compare value
	logic [word_data_w-1:0] counter;	// running count
	timer_reg_e reg_sel;	// decoded index
	logic access;	// strobed cycle
	logic rd_acc;
	logic wr_acc;
	logic expr_flag;	// count reached compare while running
	logic [word_data_w-1:0] rd_mux;	// value for the read

	assign access = !bus.cs_n && !bus.as_n;
	assign rd_acc = access && (bus.rw == bus_read);
	assign wr_acc = access && (bus.rw == bus_write);
	assign reg_sel = timer_reg_e'(bus.addr);
	assign expr_flag = start && (counter == expr_val);

	// register read select
	always_comb
	begin
		rd_mux = '0;
		case (reg_sel)
			timer_ctrl:
			begin
				rd_mux[timer_mode_loc] = mode;
				rd_mux[timer_start_loc] = start;
			end
			timer_intr: rd_mux[timer_irq_loc] = irq;
			timer_expr: rd_mux = expr_val;
			timer_counter: rd_mux = counter;
			default: rd_mux = '0;
		endcase
	end

	// bus answer one cycle after the strobe
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			bus.rdy_n <= 1'b1;
			bus.rd_data <= '0;
		end
		else
		begin
			bus.rdy_n <= !access;
			bus.rd_data <= rd_acc ? rd_mux : '0;	// zero outside the answer cycle
		end
	end

	// control, compare and count registers
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			mode <= timer_one_shot;
			start <= 1'b0;
			irq <= 1'b0;
			expr_val <= '0;
			counter <= '0;
		end
		else
		begin
			// ctrl write beats one-shot stop
			if (wr_acc && (reg_sel == timer_ctrl))
			begin
				start <= bus.wr_data[timer_start_loc];
				mode <= timer_mode_e'(bus.wr_data[timer_mode_loc]);
			end
			else if (expr_flag && (mode == timer_one_shot))
			begin
				start <= 1'b0;	// single run done
			end

			// expiry beats a clearing write
			if (expr_flag)
			begin
				irq <= 1'b1;
			end
			else if (wr_acc && (reg_sel == timer_intr))
			begin
				irq <= bus.wr_data[timer_irq_loc];
			end

			if (wr_acc && (reg_sel == timer_expr))
			begin
				expr_val <= bus.wr_data;
			end

			// write, then wrap, then count
			if (wr_acc && (reg_sel == timer_counter))
			begin
				counter <= bus.wr_data;
			end
			else if (expr_flag)
			begin
				counter <= '0;	// period is expr + 1
			end
			else if (start)
			begin
				counter <= counter + 1'b1;
			end
		end
	end

endmodule

/* source/gpio.sv */
`timescale 1ns/10ps
// general purpose i/o port with output and direction latches and a synchronised input
module gpio (
	input logic clk,
	input logic reset,
	periph_bus_if.slave bus,
	input logic [periph_pkg::gpio_w-1:0] gpio_in,	// async pins
	output logic [periph_pkg::gpio_w-1:0] gpio_out,
	output logic [periph_pkg::gpio_w-1:0] gpio_oe	// 1 = pin driven
);
	import periph_pkg::*;

	logic [gpio_w-1:0] out_data;	// output latch
	logic [gpio_w-1:0] dir_reg;	// direction latch
	logic [gpio_w-1:0] sync_meta;	// first sync stage
	logic [gpio_w-1:0] in_data;	// second stage, readable
	gpio_reg_e reg_sel;
	logic access;
	logic rd_acc;
	logic wr_acc;
	logic [word_data_w-1:0] rd_mux;

	assign access = !bus.cs_n && !bus.as_n;
	assign rd_acc = access && (bus.rw == bus_read);
	assign wr_acc = access && (bus.rw == bus_write);
	assign reg_sel = gpio_reg_e'(bus.addr);

	// zero extended register view
	always_comb
	begin
		rd_mux = '0;
		case (reg_sel)
			gpio_out_data: rd_mux[gpio_w-1:0] = out_data;
			gpio_dir: rd_mux[gpio_w-1:0] = dir_reg;
			gpio_in_data: rd_mux[gpio_w-1:0] = in_data;
			default: rd_mux = '0;	// index 3 unused
		endcase
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			bus.rdy_n <= 1'b1;
			bus.rd_data <= '0;
			out_data <= '0;
			dir_reg <= '0;	// all pins input
			sync_meta <= '0;
			in_data <= '0;
		end
		else
		begin
			bus.rdy_n <= !access;
			bus.rd_data <= rd_acc ? rd_mux : '0;
			if (wr_acc && (reg_sel == gpio_out_data))
			begin
				out_data <= bus.wr_data[gpio_w-1:0];
			end
			if (wr_acc && (reg_sel == gpio_dir))
			begin
				dir_reg <= bus.wr_data[gpio_w-1:0];
			end
			// two flops, visible two cycles after the pin moves
			sync_meta <= gpio_in;
			in_data <= sync_meta;
		end
	end

	assign gpio_out = out_data;
	assign gpio_oe = dir_reg;	// direction drives the pad enables

endmodule

/* source/periph_top.sv */
`timescale 1ns/10ps
// peripheral subsystem top joining the bus decoder, interval timer and i/o port
module periph_top (
	input logic clk,
	input logic reset,
	// master port
	input logic cs_n,
	input logic as_n,
	input periph_pkg::bus_rw_e rw,
	input logic [periph_pkg::addr_w-1:0] addr,
	input logic [periph_pkg::word_data_w-1:0] wr_data,
	output logic [periph_pkg::word_data_w-1:0] rd_data,
	output logic rdy_n,
	// timer interrupt, level
	output logic irq,
	// pins
	input logic [periph_pkg::gpio_w-1:0] gpio_in,
	output logic [periph_pkg::gpio_w-1:0] gpio_out,
	output logic [periph_pkg::gpio_w-1:0] gpio_oe
);

	periph_bus_if timer_bus ();	// decoder to timer
	periph_bus_if gpio_bus ();	// decoder to gpio

	bus_decoder u_bus_decoder (
		.clk (clk),
		.reset (reset),
		.cs_n (cs_n),
		.as_n (as_n),
		.rw (rw),
		.addr (addr),
		.wr_data (wr_data),
		.rd_data (rd_data),
		.rdy_n (rdy_n),
		.timer_bus (timer_bus.master),
		.gpio_bus (gpio_bus.master)
	);

	timer u_timer (
		.clk (clk),
		.reset (reset),
		.bus (timer_bus.slave),
		.irq (irq)
	);

	gpio u_gpio (
		.clk (clk),
		.reset (reset),
		.bus (gpio_bus.slave),
		.gpio_in (gpio_in),
		.gpio_out (gpio_out),
		.gpio_oe (gpio_oe)
	);

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/10ps
// testbench clock source, free running with an 8 ns period
module tb_clock (
	output logic clk
);

	initial
	begin
		clk = 1'b0;	// known level at time zero
		forever
		begin
			#4 clk = ~clk;	// half period, 125 MHz
		end
	end

endmodule

/* tests/periph_props.sv */
`timescale 1ns/10ps
// bus ready and interrupt timing properties for the peripheral subsystem top
module periph_props (
	input logic clk,
	input logic reset,
	input logic cs_n,
	input logic as_n,
	input periph_pkg::bus_rw_e rw,
	input logic [periph_pkg::addr_w-1:0] addr,
	input logic [periph_pkg::word_data_w-1:0] rd_data,
	input logic rdy_n,
	input logic irq
);
	import periph_pkg::*;

	int fail_count = 0;	// read by the testbench at the end
	logic access;	// strobed cycle at the master port
	logic intr_wr;	// write to timer intr

	assign access = !cs_n && !as_n;
	assign intr_wr = access && (rw == bus_write)
		&& (addr[addr_w-1 -: slave_sel_w] == timer_region)
		&& (addr[reg_addr_w-1:0] == timer_intr);

	// ready one cycle after every access, mapped or not
	ready_after_access: assert property (@(posedge clk) disable iff (!reset)
		access |=> !rdy_n)
		else begin fail_count++; $error("rdy_n stayed high after an access"); end

	// no stray ready
	ready_only_after_access: assert property (@(posedge clk) disable iff (!reset)
		!rdy_n |-> $past(access))
		else begin fail_count++; $error("rdy_n low without a preceding access"); end

	// idle bus carries zero data
	idle_data_zero: assert property (@(posedge clk) disable iff (!reset)
		rdy_n |-> (rd_data == '0))
		else begin fail_count++; $error("rd_data nonzero while rdy_n high"); end

	// irq rises from expiry only, never right after an intr write
	irq_rise_clean: assert property (@(posedge clk) disable iff (!reset)
		$rose(irq) |-> !$past(intr_wr))
		else begin fail_count++; $error("irq rose right after an intr write"); end

endmodule

bind periph_top periph_props props_inst (
	.clk (clk),
	.reset (reset),
	.cs_n (cs_n),
	.as_n (as_n),
	.rw (rw),
	.addr (addr),
	.rd_data (rd_data),
	.rdy_n (rdy_n),
	.irq (irq)
);

/* tests/periph_tb.sv */
`timescale 1ns/10ps
// testbench for the peripheral subsystem, register access, timer modes, gpio input and unmapped decode
module periph_tb;
	import periph_pkg::*;

	localparam int wait_limit = 200;	// cycles before any wait gives up

	logic clk;
	logic reset;
	logic cs_n;
	logic as_n;
	bus_rw_e rw;
	logic [addr_w-1:0] addr;
	logic [word_data_w-1:0] wr_data;
	logic [word_data_w-1:0] rd_data;
	logic rdy_n;
	logic irq;
	logic [gpio_w-1:0] gpio_in;
	logic [gpio_w-1:0] gpio_out;
	logic [gpio_w-1:0] gpio_oe;

	logic [31:0] lfsr_state = 32'hbb72_bfc1;	// random source
	int cycle = 0;	// rising edges so far
	int errors = 0;	// testbench check failures
	int tests_run = 0;
	int tests_failed = 0;

	tb_clock u_clock (.clk (clk));

	periph_top UUT (
		.clk (clk),
		.reset (reset),
		.cs_n (cs_n),
		.as_n (as_n),
		.rw (rw),
		.addr (addr),
		.wr_data (wr_data),
		.rd_data (rd_data),
		.rdy_n (rdy_n),
		.irq (irq),
		.gpio_in (gpio_in),
		.gpio_out (gpio_out),
		.gpio_oe (gpio_oe)
	);

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr_state[31]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic [addr_w-1:0] reg_addr(input logic [1:0] region,
		input logic [1:0] idx);
		return {region, {(addr_w-slave_sel_w-reg_addr_w){1'b0}}, idx};
	endfunction

	function automatic int fault_count();
		return errors + UUT.props_inst.fail_count;	// tb checks plus bound properties
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic finish_run();
		$display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, UUT.props_inst.fail_count);
		if (fault_count() == 0)
		begin
			$display("SIMULATION PASSED");
		end
		else
		begin
			$display("SIMULATION FAILED");
		end
		$finish;
	endtask

	task automatic end_test(input string name, input int mark);
		tests_run++;
		if (fault_count() == mark)
		begin
			$display("test %s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: %0d failures", name, fault_count() - mark);
		end
	endtask

	// drop strobes, then wait for ready and take the data
	task automatic finish_access(input string what, output logic [31:0] data);
		int lat;
		@(negedge clk);
		cs_n = 1'b1;
		as_n = 1'b1;
		lat = 1;	// one edge already passed
		while (rdy_n && lat < wait_limit)
		begin
			@(negedge clk);
			lat++;
		end
		if (rdy_n)
		begin
			$display("timeout: no ready after %s", what);
			errors++;
		end
		else
		begin
			check_value("rdy_n latency", lat, 32'd1);
			data = rd_data;
		end
	endtask

	task automatic write_reg(input logic [addr_w-1:0] a, input logic [31:0] d);
		logic [31:0] unused_data;
		@(negedge clk);
		cs_n = 1'b0;
		as_n = 1'b0;
		rw = bus_write;
		addr = a;
		wr_data = d;
		finish_access("bus write", unused_data);
	endtask

	task automatic read_reg(input logic [addr_w-1:0] a, output logic [31:0] d);
		@(negedge clk);
		cs_n = 1'b0;
		as_n = 1'b0;
		rw = bus_read;
		addr = a;
		finish_access("bus read", d);
	endtask

	// polls at falling edges, returns the edge count at the change
	task automatic wait_irq(input logic level, output int at_cycle);
		int n;
		n = 0;
		while (irq !== level && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (irq !== level)
		begin
			$display("timeout: irq did not reach %b within %0d cycles", level, wait_limit);
			errors++;
		end
		at_cycle = cycle;
	endtask

	initial
	begin
		logic [31:0] r;
		logic [31:0] data;
		logic [31:0] out_v;
		logic [31:0] dir_v;
		logic [31:0] expr_v;
		int t_prev;
		int t_now;
		int mark;

		reset = 1'b0;
		cs_n = 1'b1;
		as_n = 1'b1;
		rw = bus_read;
		addr = '0;
		wr_data = '0;
		gpio_in = '0;
		repeat (16) @(negedge clk);
		reset = 1'b1;

		// random values read back from timer expr and gpio latches
		mark = fault_count();
		rand_bits(32, expr_v);
		write_reg(reg_addr(timer_region, timer_expr), expr_v);
		read_reg(reg_addr(timer_region, timer_expr), data);
		check_value("timer expr", data, expr_v);
		rand_bits(gpio_w, out_v);
		write_reg(reg_addr(gpio_region, gpio_out_data), out_v);
		read_reg(reg_addr(gpio_region, gpio_out_data), data);
		check_value("gpio out_data", data, out_v);
		rand_bits(gpio_w, dir_v);
		write_reg(reg_addr(gpio_region, gpio_dir), dir_v);
		read_reg(reg_addr(gpio_region, gpio_dir), data);
		check_value("gpio dir", data, dir_v);
		end_test("register access", mark);

		// expr of at least 4 keeps the clear clear of the next expiry
		mark = fault_count();
		rand_bits(3, r);
		expr_v = 32'd4 + (r & 32'h7);
		write_reg(reg_addr(timer_region, timer_counter), 32'd0);
		write_reg(reg_addr(timer_region, timer_expr), expr_v);
		write_reg(reg_addr(timer_region, timer_ctrl), 32'h3);	// periodic, start
		wait_irq(1'b1, t_prev);
		for (int i = 0; i < 3; i++)
		begin
			write_reg(reg_addr(timer_region, timer_intr), 32'd0);
			check_value("irq after clear", {31'd0, irq}, 32'd0);
			wait_irq(1'b1, t_now);
			check_value("irq period", t_now - t_prev, expr_v + 32'd1);
			t_prev = t_now;
		end
		write_reg(reg_addr(timer_region, timer_ctrl), 32'h0);	// stop
		write_reg(reg_addr(timer_region, timer_intr), 32'd0);
		check_value("irq after stop", {31'd0, irq}, 32'd0);
		end_test("periodic mode", mark);

		// single expiry then stop
		mark = fault_count();
		rand_bits(3, r);
		expr_v = 32'd2 + (r & 32'h7);
		write_reg(reg_addr(timer_region, timer_counter), 32'd0);
		write_reg(reg_addr(timer_region, timer_expr), expr_v);
		write_reg(reg_addr(timer_region, timer_ctrl), 32'h1);	// one-shot, start
		wait_irq(1'b1, t_now);
		read_reg(reg_addr(timer_region, timer_ctrl), data);
		check_value("timer ctrl", data, 32'd0);
		read_reg(reg_addr(timer_region, timer_counter), data);
		check_value("timer counter", data, 32'd0);
		repeat (10) @(negedge clk);
		read_reg(reg_addr(timer_region, timer_counter), data);
		check_value("timer counter held", data, 32'd0);
		check_value("irq held", {31'd0, irq}, 32'd1);
		end_test("one-shot mode", mark);

		// clear, then stays low with timer stopped
		mark = fault_count();
		write_reg(reg_addr(timer_region, timer_intr), 32'd0);
		check_value("irq", {31'd0, irq}, 32'd0);
		for (int i = 0; i < 20; i++)
		begin
			@(negedge clk);
			check_value("irq stopped", {31'd0, irq}, 32'd0);
		end
		// zero write with irq already low must not raise it
		write_reg(reg_addr(timer_region, timer_intr), 32'd0);
		check_value("irq after idle clear", {31'd0, irq}, 32'd0);
		read_reg(reg_addr(timer_region, timer_intr), data);
		check_value("timer intr", data, 32'd0);
		end_test("interrupt clear", mark);

		// two flop synchroniser, then read in_data
		mark = fault_count();
		rand_bits(gpio_w, r);
		@(negedge clk);
		gpio_in = r[gpio_w-1:0];
		repeat (2) @(negedge clk);
		read_reg(reg_addr(gpio_region, gpio_in_data), data);
		check_value("gpio in_data", data, r & 32'hff);
		rand_bits(gpio_w, dir_v);
		write_reg(reg_addr(gpio_region, gpio_dir), dir_v);
		check_value("gpio_oe", {24'd0, gpio_oe}, dir_v);
		check_value("gpio_out", {24'd0, gpio_out}, out_v);
		end_test("gpio input", mark);

		// regions 2 and 3 answer zero and touch nothing
		mark = fault_count();
		rand_bits(32, r);
		write_reg(reg_addr(2'd2, timer_expr), r);
		write_reg(reg_addr(2'd3, gpio_out_data), r);
		write_reg(reg_addr(2'd3, gpio_dir), ~r);
		read_reg(reg_addr(2'd2, timer_expr), data);
		check_value("region 2 rd_data", data, 32'd0);
		read_reg(reg_addr(2'd3, gpio_in_data), data);
		check_value("region 3 rd_data", data, 32'd0);
		read_reg(reg_addr(timer_region, timer_expr), data);
		check_value("timer expr kept", data, expr_v);
		read_reg(reg_addr(gpio_region, gpio_out_data), data);
		check_value("gpio out_data kept", data, out_v);
		read_reg(reg_addr(gpio_region, gpio_dir), data);
		check_value("gpio dir kept", data, dir_v);
		end_test("unmapped region", mark);

		finish_run();
	end

endmodule

/* vlog.f */
source/periph_pkg.sv
source/periph_bus_if.sv
source/bus_decoder.sv
source/timer.sv
source/gpio.sv
source/periph_top.sv
tests/tb_clock.sv
tests/periph_props.sv
tests/periph_tb.sv

/* Makefile */
# Verilator build for the peripheral subsystem testbench

OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module periph_tb

sim:
	verilator --binary --timing --assert -f vlog.f --top-module periph_tb \
		-Mdir $(OBJ_DIR) -o periph_sim
	./$(OBJ_DIR)/periph_sim +verilator+error+limit+1000 | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
